// File: sim.f
+incdir+.
cpu_isa_pkg.sv
cpu_core_pkg.sv
cpu_sequencer.sv
cpu_reg_file.sv
cpu_decode.sv
cpu_execute.sv
cpu_writeback.sv
serial_cpu.sv
serial_cpu_asserts.sv
tb_clock_gen.sv
tb_serial_cpu.sv

// File: Makefile
# Verilator flow for the serial CPU testbench
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
TOP       ?= tb_serial_cpu
FILELIST  ?= sim.f
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: tb_serial_cpu.sv
// Serial CPU testbench
// builds three random programs, runs them through an
// instruction set model and checks the core's stores,
// PC steps and done pulses against that model
module tb_serial_cpu;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    localparam int          NUM_PROGS = 3;
    localparam int          PROG_LEN  = 61;
    localparam logic [31:0] SEED      = 32'h9a09a490;

    logic   clk;
    logic   rst_n;
    logic   start;
    instr_t i_datain;
    word_t  d_datain;
    logic   done;
    addr_t  i_addr;
    addr_t  d_addr;
    logic   d_we;
    word_t  d_dataout;

    // bus memories
    instr_t imem [256];
    word_t  dmem [256];

    // model state, carried across programs
    word_t  m_regs [8];
    word_t  m_mem [256];
    logic   m_zero;

    logic [23:0] exp_stores [$];
    addr_t       exp_pcs [$];
    addr_t       prog_base [$];
    int          exec_count [$];

    int errors       = 0;
    int store_count  = 0;
    int change_count = 0;
    int done_count   = 0;
    int cycle_count  = 0;
    int cycle_limit  = 100000;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) u_clock_gen
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    serial_cpu u_serial_cpu
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .i_datain  (i_datain),
        .d_datain  (d_datain),
        .done      (done),
        .i_addr    (i_addr),
        .d_addr    (d_addr),
        .d_we      (d_we),
        .d_dataout (d_dataout)
    );

    // both memories answer combinationally
    assign i_datain = imem[i_addr];
    assign d_datain = dmem[d_addr];

    always @(posedge clk)
    begin
        if (d_we)
            dmem[d_addr] <= d_dataout;
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycle_count <= cycle_count + 1;
            if (cycle_count > cycle_limit)
            begin
                $display("timeout, the run went past %0d cycles", cycle_limit);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    function automatic word_t fill_word(addr_t a);
        return {a ^ 8'hc3, ~a};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // program generator
    // --------------------------------------------------
    // r0 is never written, so BZ/BNZ on r0 jump to imm8
    function automatic instr_t random_op(addr_t here, addr_t last);
        opcode_e  op;
        reg_idx_t r1;
        reg_idx_t r2;
        reg_idx_t r3;
        addr_t    target;
        do
            op = opcode_e'(5'($urandom_range(15, 0)));
        while (op == HALT);
        r1 = 3'($urandom_range(7, 1));
        r2 = 3'($urandom_range(7, 0));
        // equal sources often give a zero result
        r3 = ($urandom_range(1, 0) == 0) ? r2 : 3'($urandom_range(7, 0));
        // forward only, never past the HALT
        target = here + 8'd1 + 8'($urandom_range(3, 0));
        if (target > last)
            target = last;
        case (op)
            SET, ADDI, SUBI: return {op, r1, 8'($urandom_range(255, 0))};
            JUMP, BZ, BNZ:   return {op, 3'd0, target};
            LOAD, STORE:     return {op, r1, 1'b0, r2, 4'($urandom_range(15, 0))};
            default:         return {op, r1, 1'b0, r2, 1'b0, r3};
        endcase
    endfunction

    task automatic make_program(input addr_t base);
        addr_t here;
        addr_t last;
        here = base;
        last = base + 8'(PROG_LEN - 1);
        while (here != last)
        begin
            imem[here] = random_op(here, last);
            here++;
            // a store of a random register after each instruction
            if (here != last)
            begin
                imem[here] = {STORE, 3'($urandom_range(7, 0)), 1'b0,
                              3'($urandom_range(7, 0)), 4'($urandom_range(15, 0))};
                here++;
            end
        end
        imem[last] = {HALT, 11'h000};
    endtask

    // --------------------------------------------------
    // instruction set model
    // --------------------------------------------------
    task automatic run_model(input addr_t base, output int count, output addr_t next_pc);
        addr_t    pc;
        addr_t    ea;
        instr_t   ins;
        opcode_e  op;
        reg_idx_t r1;
        reg_idx_t r2;
        reg_idx_t r3;
        word_t    res;
        logic     halted;
        pc     = base;
        count  = 0;
        halted = 1'b0;
        while (!halted)
        begin
            ins = imem[pc];
            op  = opcode_e'(ins[15:11]);
            r1  = ins[10:8];
            r2  = ins[6:4];
            r3  = ins[2:0];
            ea  = m_regs[r2][7:0] + {4'h0, ins[3:0]};
            case (op)
                SET:      res = {8'h00, ins[7:0]};
                ADDI:     res = m_regs[r1] + {8'h00, ins[7:0]};
                SUBI:     res = m_regs[r1] - {8'h00, ins[7:0]};
                ADD:      res = m_regs[r2] + m_regs[r3];
                SUB, CMP: res = m_regs[r2] - m_regs[r3];
                AND:      res = m_regs[r2] & m_regs[r3];
                OR:       res = m_regs[r2] | m_regs[r3];
                XOR:      res = m_regs[r2] ^ m_regs[r3];
                LOAD:     res = m_mem[ea];
                default:  res = '0;
            endcase
            if (op inside {SET, ADDI, SUBI, ADD, SUB, CMP, AND, OR, XOR})
                m_zero = (res == 16'h0000);
            if (op inside {SET, ADDI, SUBI, ADD, SUB, AND, OR, XOR, LOAD})
                m_regs[r1] = res;
            if (op == STORE)
            begin
                m_mem[ea] = m_regs[r1];
                exp_stores.push_back({ea, m_regs[r1]});
            end
            if (op == JUMP)
                pc = ins[7:0];
            else if (((op == BZ) && m_zero) || ((op == BNZ) && !m_zero))
                pc = m_regs[r1][7:0] + ins[7:0];
            else
                pc = pc + 8'd1;
            exp_pcs.push_back(pc);
            count++;
            halted = (op == HALT);
        end
        next_pc = pc;
    endtask

    // --------------------------------------------------
    // bus monitor, samples on the falling edge
    // --------------------------------------------------
    task automatic watch_buses();
        logic [23:0] st;
        addr_t       last_addr;
        last_addr = '0;
        forever
        begin
            @(negedge clk);
            if (d_we)
            begin
                if (exp_stores.size() == 0)
                begin
                    $display("store to address %h when the model expects none", d_addr);
                    errors++;
                end
                else
                begin
                    st = exp_stores.pop_front();
                    check_value("d_addr", 32'(d_addr), 32'(st[23:16]));
                    check_value("d_dataout", 32'(d_dataout), 32'(st[15:0]));
                    store_count++;
                end
            end
            if (i_addr != last_addr)
            begin
                if (exp_pcs.size() == 0)
                begin
                    $display("i_addr moved to %h after the model stopped", i_addr);
                    errors++;
                end
                else
                    check_value("i_addr", 32'(i_addr), 32'(exp_pcs.pop_front()));
                change_count++;
            end
            last_addr = i_addr;
            if (done)
                done_count++;
        end
    endtask

    initial
    begin
        addr_t base;
        addr_t next_base;
        int    count;
        int    changes_before;
        int    assert_fails;
        start = 1'b0;
        void'($urandom(SEED));
        m_regs = '{default: '0};
        m_zero = 1'b0;
        base   = 8'h00;
        repeat (256)
        begin
            imem[base] = '0;
            dmem[base] <= fill_word(base);
            m_mem[base] = fill_word(base);
            base++;
        end

        // each program starts one past the previous HALT
        cycle_limit = 100;
        base        = 8'h00;
        repeat (NUM_PROGS)
        begin
            make_program(base);
            run_model(base, count, next_base);
            prog_base.push_back(base);
            exec_count.push_back(count);
            cycle_limit += 5 * count + 20;
            base = next_base;
        end

        wait (rst_n === 1'b1);
        fork
            watch_buses();
        join_none

        // idle core after reset
        repeat (4)
        begin
            @(negedge clk);
            check_value("done", 32'(done), 32'h0);
            check_value("d_we", 32'(d_we), 32'h0);
            check_value("i_addr", 32'(i_addr), 32'h0);
        end

        changes_before = 0;
        while (prog_base.size() > 0)
        begin
            base  = prog_base.pop_front();
            count = exec_count.pop_front();
            check_value("i_addr", 32'(i_addr), 32'(base));
            @(posedge clk);
            #1 start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;
            do
                @(negedge clk);
            while (done !== 1'b1);
            @(negedge clk);
            check_value("done", 32'(done), 32'h0);
            check_value("retired count", 32'(change_count - changes_before), 32'(count));
            changes_before = change_count;
        end

        @(negedge clk);
        check_value("done pulses", 32'(done_count), 32'(NUM_PROGS));
        check_value("stores left", 32'(exp_stores.size()), 32'h0);
        check_value("pc steps left", 32'(exp_pcs.size()), 32'h0);
        assert_fails = u_serial_cpu.u_asserts.we_fails + u_serial_cpu.u_asserts.done_fails
                     + u_serial_cpu.u_asserts.pulse_fails
                     + u_serial_cpu.u_asserts.i_addr_fails;
        $display("errors %0d, assertion failures %0d, stores %0d, pc steps %0d",
                 errors, assert_fails, store_count, change_count);
        if ((errors == 0) && (assert_fails == 0))
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset
// free running clock, active low reset held for a fixed
// number of cycles and released just after a rising edge
module tb_clock_gen
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
)
(
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: serial_cpu_asserts.sv
// Serial CPU timing checks
// bound into the core, watches the data write strobe, the
// done pulse and the instruction address against the state
module serial_cpu_asserts
(
    input logic                     clk,
    input logic                     rst_n,
    input cpu_core_pkg::cpu_state_e state,
    input logic                     d_we,
    input logic                     done,
    input cpu_core_pkg::addr_t      i_addr
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpu_core_pkg::*;

    int we_fails     = 0;
    int done_fails   = 0;
    int pulse_fails  = 0;
    int i_addr_fails = 0;

    // write strobe only while the data bus is in use
    we_in_mem: assert property (@(posedge clk) disable iff (!rst_n)
        d_we |-> (state == MEM))
    else
    begin
        $error("d_we high outside the MEM state");
        we_fails++;
    end

    done_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (state == IDLE))
    else
    begin
        $error("done high outside the IDLE state");
        done_fails++;
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
    else
    begin
        $error("done held for more than one cycle");
        pulse_fails++;
    end

    // pc moves only when an instruction retires
    i_addr_after_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (i_addr != $past(i_addr)) |-> ($past(state) == WB))
    else
    begin
        $error("i_addr changed outside the end of WB");
        i_addr_fails++;
    end

endmodule

bind serial_cpu serial_cpu_asserts u_asserts
(
    .clk    (clk),
    .rst_n  (rst_n),
    .state  (state),
    .d_we   (d_we),
    .done   (done),
    .i_addr (i_addr)
);

// File: serial_cpu.sv
// Serial CPU top level
// five-state core with separate instruction and data buses,
// started by start and reporting a HALT through done
`include "cpu_consts.svh"

module serial_cpu
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  cpu_isa_pkg::instr_t i_datain,
    input  cpu_core_pkg::word_t d_datain,
    output logic                done,
    output cpu_core_pkg::addr_t i_addr,
    output cpu_core_pkg::addr_t d_addr,
    output logic                d_we,
    output cpu_core_pkg::word_t d_dataout
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    cpu_state_e state;
    logic       retire_halt;
    logic       zero_flag;
    logic       wr_en;
    reg_idx_t   rd_a_idx;
    reg_idx_t   rd_b_idx;
    reg_idx_t   wr_idx;
    word_t      rd_a_data;
    word_t      rd_b_data;
    word_t      wr_data;
    word_t      opnd_a;
    word_t      opnd_b;
    word_t      store_data;
    word_t      result;
    instr_t     ex_instr;
    instr_t     mem_instr;
    addr_t      pc;

    cpu_sequencer u_sequencer
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .retire_halt (retire_halt),
        .state       (state),
        .done        (done)
    );

    cpu_reg_file u_reg_file
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

    cpu_decode u_decode
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .i_datain   (i_datain),
        .rd_a_data  (rd_a_data),
        .rd_b_data  (rd_b_data),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .ex_instr   (ex_instr),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .store_data (store_data)
    );

    cpu_execute u_execute
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .ex_instr   (ex_instr),
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .store_data (store_data),
        .mem_instr  (mem_instr),
        .result     (result),
        .zero_flag  (zero_flag),
        .d_we       (d_we),
        .d_dataout  (d_dataout)
    );

    cpu_writeback u_writeback
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .mem_instr   (mem_instr),
        .result      (result),
        .zero_flag   (zero_flag),
        .d_datain    (d_datain),
        .pc          (pc),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .retire_halt (retire_halt)
    );

    // bus addresses
    assign i_addr = pc;
    assign d_addr = result[`CPU_ADDR_W-1:0];

endmodule

// File: cpu_writeback.sv
// CPU memory and write-back stages
// picks load data or ALU result, resolves branches,
// advances the PC and writes the destination register
`include "cpu_consts.svh"

module cpu_writeback
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_core_pkg::cpu_state_e state,
    input  cpu_isa_pkg::instr_t      mem_instr,
    input  cpu_core_pkg::word_t      result,
    input  logic                     zero_flag,
    input  cpu_core_pkg::word_t      d_datain,
    output cpu_core_pkg::addr_t      pc,
    output logic                     wr_en,
    output cpu_core_pkg::reg_idx_t   wr_idx,
    output cpu_core_pkg::word_t      wr_data,
    output logic                     retire_halt
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    instr_t  wb_instr;
    opcode_e mem_op;
    opcode_e wb_op;
    word_t   wb_data;
    logic    take_branch;

    assign mem_op = opcode_e'(mem_instr[`CPU_OP_LSB +: `CPU_OP_W]);
    assign wb_op  = opcode_e'(wb_instr[`CPU_OP_LSB +: `CPU_OP_W]);

    // flag still holds the last flag-setting result
    assign take_branch = (wb_op == JUMP)
                      || ((wb_op == BZ) && zero_flag)
                      || ((wb_op == BNZ) && !zero_flag);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_instr <= '0;
            pc       <= '0;
        end
        else if (state == MEM)
            wb_instr <= mem_instr;
        else if (state == WB)
            pc <= take_branch ? wb_data[`CPU_ADDR_W-1:0] : pc + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (state == MEM)
            wb_data <= (mem_op == LOAD) ? d_datain : result;
    end

    assign wr_en       = (state == WB)
                      && (wb_op inside {SET, ADD, ADDI, SUB, SUBI, AND, OR, XOR, LOAD});
    assign wr_idx      = wb_instr[`CPU_R1_LSB +: `CPU_REG_IDX_W];
    assign wr_data     = wb_data;
    assign retire_halt = (wb_op == HALT);

endmodule

// File: cpu_execute.sv
// CPU execute stage
// ALU, zero flag, result register and the data bus write
// strobe and write data for STORE
`include "cpu_consts.svh"

module cpu_execute
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_core_pkg::cpu_state_e state,
    input  cpu_isa_pkg::instr_t      ex_instr,
    input  cpu_core_pkg::word_t      opnd_a,
    input  cpu_core_pkg::word_t      opnd_b,
    input  cpu_core_pkg::word_t      store_data,
    output cpu_isa_pkg::instr_t      mem_instr,
    output cpu_core_pkg::word_t      result,
    output logic                     zero_flag,
    output logic                     d_we,
    output cpu_core_pkg::word_t      d_dataout
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    opcode_e ex_op;
    word_t   alu_out;
    logic    sets_flag;

    assign ex_op = opcode_e'(ex_instr[`CPU_OP_LSB +: `CPU_OP_W]);

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb
    begin
        case (ex_op)
            SET:              alu_out = opnd_b;
            AND:              alu_out = opnd_a & opnd_b;
            OR:               alu_out = opnd_a | opnd_b;
            XOR:              alu_out = opnd_a ^ opnd_b;
            SUB, SUBI, CMP:   alu_out = opnd_a - opnd_b;
            // ADD, ADDI, addresses and branch targets
            default:          alu_out = opnd_a + opnd_b;
        endcase
    end

    assign sets_flag = ex_op inside {SET, ADD, ADDI, SUB, SUBI, CMP, AND, OR, XOR};

    // --------------------------------------------------
    // stage registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_instr <= '0;
            zero_flag <= 1'b0;
            d_we      <= 1'b0;
        end
        else if (state == EX)
        begin
            mem_instr <= ex_instr;
            if (sets_flag)
                zero_flag <= (alu_out == '0);
            d_we <= (ex_op == STORE);
        end
        else if (state == MEM)
            d_we <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (state == EX)
        begin
            result <= alu_out;
            if (ex_op == STORE)
                d_dataout <= store_data;
        end
    end

endmodule

// File: cpu_decode.sv
// CPU fetch and decode
// holds the fetched instruction, addresses the register file
// by opcode class and latches the A, B and store operands
`include "cpu_consts.svh"

module cpu_decode
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_core_pkg::cpu_state_e state,
    input  cpu_isa_pkg::instr_t      i_datain,
    input  cpu_core_pkg::word_t      rd_a_data,
    input  cpu_core_pkg::word_t      rd_b_data,
    output cpu_core_pkg::reg_idx_t   rd_a_idx,
    output cpu_core_pkg::reg_idx_t   rd_b_idx,
    output cpu_isa_pkg::instr_t      ex_instr,
    output cpu_core_pkg::word_t      opnd_a,
    output cpu_core_pkg::word_t      opnd_b,
    output cpu_core_pkg::word_t      store_data
);
    import cpu_isa_pkg::*;
    import cpu_core_pkg::*;

    instr_t   id_instr;
    opcode_e  id_op;
    reg_idx_t id_r1;
    reg_idx_t id_r2;
    reg_idx_t id_r3;
    imm8_t    id_imm;
    off4_t    id_off;
    logic     a_is_r1;
    word_t    a_sel;
    word_t    b_sel;

    // --------------------------------------------------
    // field split
    // --------------------------------------------------
    assign id_op  = opcode_e'(id_instr[`CPU_OP_LSB +: `CPU_OP_W]);
    assign id_r1  = id_instr[`CPU_R1_LSB +: `CPU_REG_IDX_W];
    assign id_r2  = id_instr[`CPU_R2_LSB +: `CPU_REG_IDX_W];
    assign id_r3  = id_instr[`CPU_R3_LSB +: `CPU_REG_IDX_W];
    assign id_imm = id_instr[`CPU_IMM_W-1:0];
    assign id_off = id_instr[`CPU_OFF_W-1:0];

    // immediate forms and branches work on r1
    assign a_is_r1  = id_op inside {SET, ADDI, SUBI, BZ, BNZ};
    assign rd_a_idx = a_is_r1 ? id_r1 : id_r2;
    // port b reads the stored register for STORE
    assign rd_b_idx = (id_op == STORE) ? id_r1 : id_r3;

    always_comb
    begin
        a_sel = (id_op == JUMP) ? '0 : rd_a_data;
        if (id_op inside {SET, ADDI, SUBI, JUMP, BZ, BNZ})
            b_sel = word_t'(id_imm);
        else if (id_op inside {LOAD, STORE})
            b_sel = word_t'(id_off);
        else
            b_sel = rd_b_data;
    end

    // --------------------------------------------------
    // instruction registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            id_instr <= '0;
            ex_instr <= '0;
        end
        else if (state == IF)
            id_instr <= i_datain;
        else if (state == ID)
            ex_instr <= id_instr;
    end

    // operands, valid from EX on
    always_ff @(posedge clk)
    begin
        if (state == ID)
        begin
            opnd_a <= a_sel;
            opnd_b <= b_sel;
            if (id_op == STORE)
                store_data <= rd_b_data;
        end
    end

endmodule

// File: cpu_reg_file.sv
// CPU register file
// eight general registers, two combinational read ports
// and one clocked write port
`include "cpu_consts.svh"

module cpu_reg_file
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  cpu_core_pkg::reg_idx_t rd_a_idx,
    input  cpu_core_pkg::reg_idx_t rd_b_idx,
    input  logic                   wr_en,
    input  cpu_core_pkg::reg_idx_t wr_idx,
    input  cpu_core_pkg::word_t    wr_data,
    output cpu_core_pkg::word_t    rd_a_data,
    output cpu_core_pkg::word_t    rd_b_data
);
    import cpu_core_pkg::*;

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_idx] <= wr_data;
    end

    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];

endmodule

// File: cpu_sequencer.sv
// CPU sequencer
// walks every instruction through IF, ID, EX, MEM and WB,
// waits in IDLE for start and pulses done after a HALT
module cpu_sequencer
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     retire_halt,
    output cpu_core_pkg::cpu_state_e state,
    output logic                     done
);
    import cpu_core_pkg::*;

    cpu_state_e next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:    if (start) next_state = IF;
            IF:      next_state = ID;
            ID:      next_state = EX;
            EX:      next_state = MEM;
            MEM:     next_state = WB;
            WB:      next_state = retire_halt ? IDLE : IF;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
            done  <= 1'b0;
        end
        else
        begin
            state <= next_state;
            // high for the first IDLE cycle only
            done  <= (state == WB) && retire_halt;
        end
    end

endmodule

// File: cpu_core_pkg.sv
// CPU core types
// data word, bus address, register index and the
// states of the instruction sequencer
`include "cpu_consts.svh"

package cpu_core_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;
    typedef logic [`CPU_ADDR_W-1:0]    addr_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // one bit flips on each step IF..WB
    typedef enum logic [2:0]
    {
        IDLE = 3'b000,
        IF   = 3'b001,
        ID   = 3'b011,
        EX   = 3'b010,
        MEM  = 3'b110,
        WB   = 3'b100
    } cpu_state_e;

endpackage

// File: cpu_isa_pkg.sv
// CPU instruction set
// opcode encoding and the types of the instruction word
// and its immediate fields
`include "cpu_consts.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_WORD_W-1:0] instr_t;
    typedef logic [`CPU_IMM_W-1:0]  imm8_t;
    typedef logic [`CPU_OFF_W-1:0]  off4_t;

    // all-zero word decodes as NOP
    typedef enum logic [`CPU_OP_W-1:0]
    {
        NOP   = 5'h00,
        HALT  = 5'h01,
        SET   = 5'h02,
        ADD   = 5'h03,
        ADDI  = 5'h04,
        SUB   = 5'h05,
        SUBI  = 5'h06,
        CMP   = 5'h07,
        AND   = 5'h08,
        OR    = 5'h09,
        XOR   = 5'h0a,
        // memory access, address is r2 + off4
        LOAD  = 5'h0b,
        STORE = 5'h0c,
        // control flow
        JUMP  = 5'h0d,
        BZ    = 5'h0e,
        BNZ   = 5'h0f
    } opcode_e;

endpackage

// File: cpu_consts.svh
// CPU constants
// word, address and register file sizes, and the bit
// positions of the fields inside an instruction word
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_WORD_W      16
`define CPU_ADDR_W      8
`define CPU_NUM_REGS    8
`define CPU_REG_IDX_W   3
`define CPU_OP_W        5
`define CPU_IMM_W       8
`define CPU_OFF_W       4

// lsb of each field, imm8 and off4 sit at bit 0
`define CPU_OP_LSB      11
`define CPU_R1_LSB      8
`define CPU_R2_LSB      4
`define CPU_R3_LSB      0

`endif
